/* eeprom_settings.svh */
`ifndef EEPROM_SETTINGS_SVH
`define EEPROM_SETTINGS_SVH

// bus timing
// CLK cycles per SCL half-period, 2 or more
`define EE_SCL_HALF 4

// device select
// fixed type code in the upper nibble of the control byte
`define EE_DEV_CODE 4'b1010

// memory geometry
// 24C16 class part, 11-bit word address
`define EE_MEM_WORDS 2048

`endif

/* eeprom_pkg.sv */
package eeprom_pkg;

    typedef logic [10:0] ee_addr_t;  // bits 10:8 go into the control byte
    typedef logic [7:0]  ee_byte_t;

    // commands from the sequencer to the bus engine
    typedef enum logic [1:0] {
        CMD_START,  // also used for repeated start
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } i2c_cmd_e;

    typedef enum logic [3:0] {
        S_IDLE, S_START, S_CTRL_W, S_ADDR, S_DATA_W,
        S_RESTART, S_CTRL_R, S_DATA_R, S_STOP, S_DONE
    } seq_state_e;

    typedef enum logic [2:0] {
        E_IDLE, E_START, E_BITS, E_ACK, E_STOP, E_END
    } eng_state_e;

endpackage

/* i2c_byte_if.sv */
interface i2c_byte_if;

    eeprom_pkg::i2c_cmd_e cmd;
    logic                 go;       // one-cycle strobe
    eeprom_pkg::ee_byte_t tx_byte;
    logic                 last;     // read answers with nack
    logic                 done;     // one-cycle, end of command
    eeprom_pkg::ee_byte_t rx_byte;
    logic                 rx_nack;  // valid with done

    modport ctrl (
        output cmd, go, tx_byte, last,
        input  done, rx_byte, rx_nack
    );

    modport engine (
        input  cmd, go, tx_byte, last,
        output done, rx_byte, rx_nack
    );

endinterface

/* i2c_bus_engine.sv */
`include "eeprom_settings.svh"

module i2c_bus_engine (
    input  logic CLK,
    input  logic RESET,
    i2c_byte_if.engine bus,
    output logic scl,
    input  logic sda_in,
    output logic sda_oe
);

    localparam int HALF = `EE_SCL_HALF;
    localparam int CW = $clog2(HALF);
    localparam logic [CW-1:0] CNT_LAST = CW'(HALF - 1);
    localparam logic [CW-1:0] CNT_MID = CW'(HALF / 2);

    eeprom_pkg::eng_state_e state;
    logic [CW-1:0] cnt;      // position inside the half-period
    logic          hi;       // second half of a bit, start or stop
    logic [2:0]    bit_cnt;
    logic          rd_mode;
    logic          last_r;
    logic          nack;
    eeprom_pkg::ee_byte_t shreg;

    logic first_cyc;
    logic mid_cyc;
    logic tick;

    assign first_cyc = (cnt == '0);  // one cycle after the SCL edge
    assign mid_cyc = (cnt == CNT_MID);
    assign tick = (cnt == CNT_LAST);

    assign bus.done = (state == eeprom_pkg::E_END);
    assign bus.rx_byte = shreg;
    assign bus.rx_nack = nack;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= eeprom_pkg::E_IDLE;
            cnt <= '0;
            hi <= 1'b0;
            bit_cnt <= '0;
            scl <= 1'b1;
            sda_oe <= 1'b0;
            rd_mode <= 1'b0;
            last_r <= 1'b0;
            nack <= 1'b0;
        end
        else
        begin
            if (state != eeprom_pkg::E_IDLE && state != eeprom_pkg::E_END)
            begin
                cnt <= tick ? '0 : cnt + 1'b1;
                if (tick)
                    hi <= !hi;
            end
            case (state)
                eeprom_pkg::E_IDLE:
                    if (bus.go)
                    begin
                        cnt <= '0;
                        hi <= 1'b0;
                        bit_cnt <= '0;
                        nack <= 1'b0;
                        rd_mode <= (bus.cmd == eeprom_pkg::CMD_READ);
                        last_r <= bus.last;
                        case (bus.cmd)
                            eeprom_pkg::CMD_START: state <= eeprom_pkg::E_START;
                            eeprom_pkg::CMD_STOP:  state <= eeprom_pkg::E_STOP;
                            default:               state <= eeprom_pkg::E_BITS;
                        endcase
                    end
                eeprom_pkg::E_START:
                begin
                    // release sda, scl up, then sda down while scl high
                    if (!hi && first_cyc)
                        sda_oe <= 1'b0;
                    if (!hi && tick)
                        scl <= 1'b1;
                    if (hi && first_cyc)
                        sda_oe <= 1'b1;
                    if (hi && tick)
                    begin
                        scl <= 1'b0;
                        state <= eeprom_pkg::E_END;
                    end
                end
                eeprom_pkg::E_BITS:
                begin
                    if (!hi && first_cyc)
                        sda_oe <= !rd_mode && !shreg[7];  // msb first
                    if (!hi && tick)
                        scl <= 1'b1;
                    if (hi && tick)
                    begin
                        scl <= 1'b0;
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= eeprom_pkg::E_ACK;
                    end
                end
                eeprom_pkg::E_ACK:
                begin
                    if (!hi && first_cyc)
                        sda_oe <= rd_mode && !last_r;  // master ack on reads
                    if (!hi && tick)
                        scl <= 1'b1;
                    if (hi && mid_cyc)
                        nack <= !rd_mode && sda_in;
                    if (hi && tick)
                    begin
                        scl <= 1'b0;
                        state <= eeprom_pkg::E_END;
                    end
                end
                eeprom_pkg::E_STOP:
                begin
                    if (!hi && first_cyc)
                        sda_oe <= 1'b1;
                    if (!hi && tick)
                        scl <= 1'b1;
                    if (hi && tick)
                    begin
                        sda_oe <= 1'b0;  // sda rises with scl high
                        state <= eeprom_pkg::E_END;
                    end
                end
                eeprom_pkg::E_END:
                    state <= eeprom_pkg::E_IDLE;
                default:
                    state <= eeprom_pkg::E_IDLE;
            endcase
        end
    end

    // shared shifter, on writes it reads back the bits driven
    always_ff @(posedge CLK)
    begin
        if (state == eeprom_pkg::E_IDLE && bus.go)
            shreg <= bus.tx_byte;
        else if (state == eeprom_pkg::E_BITS && hi && mid_cyc)
            shreg <= {shreg[6:0], sda_in};
    end

    a_sda_scl_low: assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_oe) |-> (!scl && !$past(scl)) ||
            ($past(state) inside {eeprom_pkg::E_START, eeprom_pkg::E_STOP}))
        else $error("sda changed while scl high outside start/stop");

    a_go_idle: assert property (@(posedge CLK) disable iff (RESET)
        bus.go |-> state == eeprom_pkg::E_IDLE)
        else $error("go issued while engine busy");

endmodule

/* eeprom_seq.sv */
`include "eeprom_settings.svh"

module eeprom_seq (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::ee_addr_t addr,
    input  eeprom_pkg::ee_byte_t wdata,
    output eeprom_pkg::ee_byte_t rdata,
    output logic                 busy,
    output logic                 ack,
    output logic                 err,
    i2c_byte_if.ctrl             bus
);

    eeprom_pkg::seq_state_e state;
    logic                   pending;  // engine command in flight
    logic                   op_rd;
    logic                   accept;
    eeprom_pkg::ee_addr_t   addr_r;
    eeprom_pkg::ee_byte_t   wdata_r;

    // a strobe is taken whenever busy is low, S_DONE included
    assign accept = (state == eeprom_pkg::S_IDLE || state == eeprom_pkg::S_DONE) && (wr || rd);
    assign busy = (state != eeprom_pkg::S_IDLE) && (state != eeprom_pkg::S_DONE);
    assign ack = (state == eeprom_pkg::S_DONE);
    assign bus.go = busy && !pending;

    // one engine command per state
    always_comb
    begin
        bus.cmd = eeprom_pkg::CMD_STOP;
        bus.tx_byte = addr_r[7:0];
        bus.last = 1'b0;
        case (state)
            eeprom_pkg::S_START,
            eeprom_pkg::S_RESTART:
                bus.cmd = eeprom_pkg::CMD_START;
            eeprom_pkg::S_CTRL_W:
            begin
                bus.cmd = eeprom_pkg::CMD_WRITE;
                bus.tx_byte = {`EE_DEV_CODE, addr_r[10:8], 1'b0};
            end
            eeprom_pkg::S_ADDR:
                bus.cmd = eeprom_pkg::CMD_WRITE;
            eeprom_pkg::S_DATA_W:
            begin
                bus.cmd = eeprom_pkg::CMD_WRITE;
                bus.tx_byte = wdata_r;
            end
            eeprom_pkg::S_CTRL_R:
            begin
                bus.cmd = eeprom_pkg::CMD_WRITE;
                bus.tx_byte = {`EE_DEV_CODE, addr_r[10:8], 1'b1};  // read bit
            end
            eeprom_pkg::S_DATA_R:
            begin
                bus.cmd = eeprom_pkg::CMD_READ;
                bus.last = 1'b1;  // single byte, nack it
            end
            default:
                bus.cmd = eeprom_pkg::CMD_STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= eeprom_pkg::S_IDLE;
            pending <= 1'b0;
            op_rd <= 1'b0;
            err <= 1'b0;
        end
        else if (accept)
        begin
            state <= eeprom_pkg::S_START;
            op_rd <= !wr;  // wr wins
            err <= 1'b0;
            pending <= 1'b0;
        end
        else if (state == eeprom_pkg::S_DONE)
            state <= eeprom_pkg::S_IDLE;
        else if (bus.go)
            pending <= 1'b1;
        else if (bus.done)
        begin
            pending <= 1'b0;
            case (state)
                eeprom_pkg::S_START:
                    state <= eeprom_pkg::S_CTRL_W;
                eeprom_pkg::S_CTRL_W:
                    state <= bus.rx_nack ? eeprom_pkg::S_STOP : eeprom_pkg::S_ADDR;
                eeprom_pkg::S_ADDR:
                    if (bus.rx_nack)
                        state <= eeprom_pkg::S_STOP;
                    else if (op_rd)
                        state <= eeprom_pkg::S_RESTART;
                    else
                        state <= eeprom_pkg::S_DATA_W;
                eeprom_pkg::S_DATA_W:
                    state <= eeprom_pkg::S_STOP;
                eeprom_pkg::S_RESTART:
                    state <= eeprom_pkg::S_CTRL_R;
                eeprom_pkg::S_CTRL_R:
                    state <= bus.rx_nack ? eeprom_pkg::S_STOP : eeprom_pkg::S_DATA_R;
                eeprom_pkg::S_DATA_R:
                    state <= eeprom_pkg::S_STOP;
                eeprom_pkg::S_STOP:
                    state <= eeprom_pkg::S_DONE;
                default:
                    state <= eeprom_pkg::S_IDLE;
            endcase
            if (bus.rx_nack)
                err <= 1'b1;  // no slave answered
        end
    end

    // request and result bytes
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_r <= addr;
            wdata_r <= wdata;
        end
        if (state == eeprom_pkg::S_DATA_R && bus.done)
            rdata <= bus.rx_byte;
    end

    a_ack_pulse: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack)
        else $error("ack longer than one cycle");

    a_go_outstanding: assert property (@(posedge CLK) disable iff (RESET)
        bus.go |=> (!bus.go until_with bus.done))
        else $error("go raised before done of previous command");

endmodule

/* eeprom_master_top.sv */
module eeprom_master_top (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::ee_addr_t addr,
    input  eeprom_pkg::ee_byte_t wdata,
    output eeprom_pkg::ee_byte_t rdata,
    output logic                 busy,
    output logic                 ack,
    output logic                 err,
    output logic                 scl,
    inout  wire                  sda
);

    logic sda_oe;

    i2c_byte_if bus_if ();

    eeprom_seq seq_i (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .busy  (busy),
        .ack   (ack),
        .err   (err),
        .bus   (bus_if.ctrl)
    );

    i2c_bus_engine eng_i (
        .CLK    (CLK),
        .RESET  (RESET),
        .bus    (bus_if.engine),
        .scl    (scl),
        .sda_in (sda),
        .sda_oe (sda_oe)
    );

    assign sda = sda_oe ? 1'b0 : 1'bz;  // open drain, pull-up on the board

endmodule

/* eeprom_model.sv */
`include "eeprom_settings.svh"

module eeprom_model (
    input  logic scl,
    inout  wire  sda,
    input  logic present
);

    logic [7:0]  mem [0:`EE_MEM_WORDS-1];
    logic [7:0]  shreg;
    logic [7:0]  rbuf;
    logic [10:0] ptr = '0;
    logic        drive_low = 1'b0;
    logic        active = 1'b0;   // between start and stop
    logic        reading = 1'b0;
    logic        rd_pend = 1'b0;  // read control byte seen
    int          bit_n = 0;
    int          byte_n = 0;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < `EE_MEM_WORDS; i++)
            mem[i] = 8'hFF;
    end

    // sda moving while scl is high means start or stop
    always @(sda)
    begin
        if (scl === 1'b1)
        begin
            active = (sda === 1'b0);
            reading = 1'b0;
            rd_pend = 1'b0;
            drive_low = 1'b0;
            bit_n = 0;
            byte_n = 0;
        end
    end

    always @(posedge scl)
    begin
        if (active)
        begin
            if (!reading)
                shreg = {shreg[6:0], sda};
            bit_n++;
        end
    end

    always @(negedge scl)
    begin
        if (!active)
            drive_low = 1'b0;
        else if (bit_n == 8 && reading)
            drive_low = 1'b0;  // master answers the byte
        else if (bit_n == 8)
        begin
            if (byte_n == 0)
            begin
                ptr[10:8] = shreg[3:1];  // page bits
                rd_pend = shreg[0];
            end
            else if (byte_n == 1)
                ptr[7:0] = shreg;
            else if (byte_n == 2 && present)
                mem[ptr] = shreg;
            drive_low = present && byte_n <= 2 &&
                (byte_n > 0 || shreg[7:4] == `EE_DEV_CODE);
            byte_n++;
        end
        else if (bit_n == 9)
        begin
            bit_n = 0;
            active = drive_low;  // a nack ends the transfer
            reading = rd_pend && drive_low;
            rd_pend = 1'b0;
            rbuf = mem[ptr];
            drive_low = reading && !rbuf[7];
        end
        else if (reading && bit_n > 0)
            drive_low = !rbuf[7 - bit_n];
    end

endmodule

/* tb_eeprom.sv */
`include "eeprom_settings.svh"

module tb_eeprom;

    localparam int NROWS = 13;
    localparam int LIMIT = NROWS * (5 * 9 + 4) * 2 * `EE_SCL_HALF * 4 + 1000;
    localparam logic OP_WR = 1'b0;
    localparam logic OP_RD = 1'b1;

    typedef struct packed {
        logic        op_rd;
        logic [10:0] addr;
        logic [7:0]  data;
        logic        present;
        logic        ignore;  // extra wr while busy
    } row_t;

    logic                 CLK = 1'b0;
    logic                 RESET = 1'b1;
    logic                 wr = 1'b0;
    logic                 rd = 1'b0;
    eeprom_pkg::ee_addr_t addr = '0;
    eeprom_pkg::ee_byte_t wdata = '0;
    logic                 present = 1'b1;
    eeprom_pkg::ee_byte_t rdata;
    logic                 busy;
    logic                 ack;
    logic                 err;
    logic                 scl;
    tri1                  sda;

    row_t       rows [NROWS];
    logic [7:0] ref_mem [0:`EE_MEM_WORDS-1];
    int         ack_cnt = 0;
    int         checks = 0;
    int         fails = 0;

    always #2 CLK = ~CLK;

    always @(negedge CLK)
    begin
        if (ack === 1'b1)
            ack_cnt++;
    end

    eeprom_master_top dut_i (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .busy  (busy),
        .ack   (ack),
        .err   (err),
        .scl   (scl),
        .sda   (sda)
    );

    eeprom_model model_i (
        .scl     (scl),
        .sda     (sda),
        .present (present)
    );

    task automatic expect_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("ERR %s got %h expected %h", name, got, exp);
            fails++;
        end
    endtask

    initial
    begin
        int fails_before;
        void'($urandom(90));
        for (int i = 0; i < `EE_MEM_WORDS; i++)
            ref_mem[i] = 8'hFF;
        // op, addr, data, present, ignore
        rows[0] = '{OP_WR, 11'h0A5, 8'h00, 1'b1, 1'b0};
        rows[1] = '{OP_RD, 11'h0A5, 8'h00, 1'b1, 1'b0};
        rows[2] = '{OP_WR, 11'h5A5, 8'h00, 1'b1, 1'b0};  // same low byte, other page
        rows[3] = '{OP_RD, 11'h0A5, 8'h00, 1'b1, 1'b0};
        rows[4] = '{OP_RD, 11'h5A5, 8'h00, 1'b1, 1'b0};
        rows[5] = '{OP_RD, 11'h3FF, 8'h00, 1'b1, 1'b0};  // never written
        rows[6] = '{OP_WR, 11'h123, 8'h00, 1'b0, 1'b0};  // no slave
        rows[7] = '{OP_RD, 11'h123, 8'h00, 1'b1, 1'b0};
        rows[8] = '{OP_WR, 11'h0A5, 8'h00, 1'b1, 1'b1};
        rows[9] = '{OP_RD, 11'h0A5, 8'h00, 1'b1, 1'b0};
        rows[10] = '{OP_RD, 11'h07E, 8'h00, 1'b1, 1'b0};  // target of the dropped wr
        rows[11] = '{OP_WR, 11'h7FF, 8'h00, 1'b1, 1'b0};
        rows[12] = '{OP_RD, 11'h7FF, 8'h00, 1'b1, 1'b0};
        for (int r = 0; r < NROWS; r++)
        begin
            if (rows[r].op_rd == OP_WR)
                rows[r].data = 8'($urandom);
        end

        repeat (8) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        expect_value("scl", scl, 1'b1);
        expect_value("sda", sda, 1'b1);
        expect_value("busy", busy, 1'b0);
        expect_value("ack", ack, 1'b0);
        expect_value("err", err, 1'b0);
        $display("reset state: %s", fails == 0 ? "ok" : "failed");

        for (int r = 0; r < NROWS; r++)
        begin
            fails_before = fails;
            present = rows[r].present;
            addr = rows[r].addr;
            wdata = rows[r].data;
            wr = !rows[r].op_rd;
            rd = rows[r].op_rd;
            @(negedge CLK);
            wr = 1'b0;
            rd = 1'b0;
            expect_value("busy", busy, 1'b1);  // rises the cycle after the strobe
            if (rows[r].ignore)
            begin
                repeat (3) @(negedge CLK);
                addr = 11'h07E;
                wdata = ~rows[r].data;
                wr = 1'b1;
                @(negedge CLK);
                wr = 1'b0;
            end
            while (ack !== 1'b1)
                @(negedge CLK);

            expect_value("err", err, !rows[r].present);
            if (rows[r].op_rd)
                expect_value("rdata", rdata, ref_mem[rows[r].addr]);
            else if (rows[r].present)
                ref_mem[rows[r].addr] = rows[r].data;
            repeat (4) @(negedge CLK);
            expect_value("busy", busy, 1'b0);
            checks++;
            assert (ack_cnt == r + 1)
            else
            begin
                $display("wrong number of ack pulses, %0d seen, %0d expected", ack_cnt, r + 1);
                fails++;
            end
            $display("row %0d %s addr %h: %s", r, rows[r].op_rd ? "read " : "write",
                rows[r].addr, fails == fails_before ? "ok" : "failed");
        end

        $display("%0d rows, %0d checks, %0d failed", NROWS, checks, fails);
        if (fails == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    // watchdog sized from the longest transaction per row
    initial
    begin
        #(LIMIT);
        $display("no ack arrived before the timeout at time %0t", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
eeprom_pkg.sv
i2c_byte_if.sv
i2c_bus_engine.sv
eeprom_seq.sv
eeprom_master_top.sv
eeprom_model.sv
tb_eeprom.sv
